/* src/pwo_pkg.sv */
// Shared definitions for the pointwise polynomial unit
//   widths, modulus, word layout
//   operation mode encoding
//   lane types and the modular add used by several stages

`default_nettype none

package pwo_pkg;

    // ====================
    // Widths and modulus
    // ====================
    localparam int COEFF_W    = 23;
    localparam int SLOT_W     = 24;
    localparam int LANES      = 4;
    localparam int WORD_W     = LANES * SLOT_W;
    localparam int ADDR_W     = 15;
    localparam int POLY_WORDS = 64;
    localparam int IDX_W      = 6;

    localparam logic [COEFF_W-1:0] PWO_Q = 23'd8380417;

    // ====================
    // Types
    // ====================
    typedef logic [COEFF_W-1:0] coeff_t;
    typedef logic [LANES-1:0][COEFF_W-1:0] lanes_t;
    typedef logic [ADDR_W-1:0] addr_t;

    typedef enum logic [1:0] {
        PWO_MUL = 2'd0,
        PWO_ADD = 2'd1,
        PWO_SUB = 2'd2
    } pwo_mode_e;

    // (x + y) mod q for x, y already below q
    function automatic coeff_t mod_add(coeff_t x, coeff_t y);
        logic [COEFF_W:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= {1'b0, PWO_Q}) begin
            s = s - {1'b0, PWO_Q};
        end
        return s[COEFF_W-1:0];
    endfunction

endpackage

`default_nettype wire

/* src/pwo_lane_if.sv */
// Operand bundle from the sequencer to the arithmetic lanes
//   one word of a, b and old c per valid cycle, plus its write address

`timescale 1ns/10ps
`default_nettype none

interface pwo_lane_if;
    import pwo_pkg::*;

    logic   valid;
    lanes_t a;
    lanes_t b;
    // Old destination word, zero unless accumulating
    lanes_t c;
    addr_t  wr_addr;

    modport src (
        output valid,
        output a,
        output b,
        output c,
        output wr_addr
    );

    modport mul_dst (
        input valid,
        input a,
        input b,
        input c,
        input wr_addr
    );

    // Adders need no accumulate term and no address
    modport add_dst (
        input valid,
        input a,
        input b
    );

endinterface

`default_nettype wire

/* src/pwo_seq.sv */
// Sequencer for one pointwise run
//   start/busy/done control and word counter
//   read address generation for a, b and c
//   operand capture and unpacking onto the lane interface

`timescale 1ns/10ps
`default_nettype none

module pwo_seq (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        start_i,
    input  pwo_pkg::pwo_mode_e          mode_i,
    input  logic                        accumulate_i,
    input  pwo_pkg::addr_t              a_base_i,
    input  pwo_pkg::addr_t              b_base_i,
    input  pwo_pkg::addr_t              c_base_i,
    output logic                        rd_en_o,
    output pwo_pkg::addr_t              a_rd_addr_o,
    output pwo_pkg::addr_t              b_rd_addr_o,
    output logic                        c_rd_en_o,
    output pwo_pkg::addr_t              c_rd_addr_o,
    input  logic [pwo_pkg::WORD_W-1:0]  a_rd_data_i,
    input  logic [pwo_pkg::WORD_W-1:0]  b_rd_data_i,
    input  logic [pwo_pkg::WORD_W-1:0]  c_rd_data_i,
    input  logic                        wr_done_i,
    output logic                        busy_o,
    output logic                        done_o,
    output pwo_pkg::pwo_mode_e          mode_o,
    pwo_lane_if.src                     lane
);
    import pwo_pkg::*;

    logic             busy_q;
    logic             done_q;
    logic             rd_en_q;
    logic [IDX_W-1:0] idx_q;
    pwo_mode_e        mode_q;
    logic             acc_q;
    logic             acc_mul;
    // Request stage delayed by the memory latency
    logic             req_vld_q;
    addr_t            wr_addr_q;

    // Slot layout: coefficient in the low 23 bits of each 24-bit slot
    function automatic lanes_t unpack_word(logic [WORD_W-1:0] w);
        lanes_t r;
        for (int i = 0; i < LANES; i++) begin
            r[i] = w[i*SLOT_W +: COEFF_W];
        end
        return r;
    endfunction

    // ====================
    // Run control
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            rd_en_q <= 1'b0;
            idx_q   <= '0;
            mode_q  <= PWO_MUL;
            acc_q   <= 1'b0;
        end else begin
            done_q <= wr_done_i;
            if (start_i && !busy_q) begin
                busy_q  <= 1'b1;
                rd_en_q <= 1'b1;
                idx_q   <= '0;
                mode_q  <= mode_i;
                acc_q   <= accumulate_i;
            end else begin
                if (rd_en_q) begin
                    idx_q <= idx_q + IDX_W'(1);
                    if (idx_q == IDX_W'(POLY_WORDS - 1)) begin
                        rd_en_q <= 1'b0;
                    end
                end
                // Last write leaves the combine stage
                if (wr_done_i) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // Accumulate only applies to multiply
    assign acc_mul = acc_q && (mode_q == PWO_MUL);

    assign rd_en_o     = rd_en_q;
    assign c_rd_en_o   = rd_en_q && acc_mul;
    assign a_rd_addr_o = a_base_i + addr_t'(idx_q);
    assign b_rd_addr_o = b_base_i + addr_t'(idx_q);
    assign c_rd_addr_o = c_base_i + addr_t'(idx_q);
    assign busy_o      = busy_q;
    assign done_o      = done_q;
    assign mode_o      = mode_q;

    // ====================
    // Operand capture
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            req_vld_q  <= 1'b0;
            lane.valid <= 1'b0;
        end else begin
            req_vld_q  <= rd_en_q;
            lane.valid <= req_vld_q;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr_q    <= c_rd_addr_o;
        lane.wr_addr <= wr_addr_q;
        lane.a       <= unpack_word(a_rd_data_i);
        lane.b       <= unpack_word(b_rd_data_i);
        lane.c       <= acc_mul ? unpack_word(c_rd_data_i) : '0;
    end

endmodule

`default_nettype wire

/* src/pwo_mul_lanes.sv */
// Four modular multipliers, one per coefficient lane
//   46-bit product folded with 2^23 = 2^13 - 1 (mod q)
//   result, old c, address and valid registered together

`timescale 1ns/10ps
`default_nettype none

module pwo_mul_lanes (
    input  logic            clk,
    input  logic            reset_n,
    pwo_lane_if.mul_dst     lane,
    output logic            valid_o,
    output pwo_pkg::lanes_t prod_o,
    output pwo_pkg::lanes_t c_o,
    output pwo_pkg::addr_t  wr_addr_o
);
    import pwo_pkg::*;

    lanes_t prod_d;

    // Three folds bring the value below 2q, then one correction
    function automatic coeff_t mod_mul(coeff_t x, coeff_t y);
        logic [2*COEFF_W-1:0] p;
        logic [36:0]          v1;
        logic [26:0]          v2;
        logic [23:0]          v3;
        p  = (2*COEFF_W)'(x) * (2*COEFF_W)'(y);
        // First fold, value below 2^36
        v1 = (37'(p[45:23]) << 13) - 37'(p[45:23]) + 37'(p[22:0]);
        // Second fold, value below 2^27
        v2 = (27'(v1[36:23]) << 13) - 27'(v1[36:23]) + 27'(v1[22:0]);
        // Third fold, value below 2^23 + 2^17
        v3 = (24'(v2[26:23]) << 13) - 24'(v2[26:23]) + 24'(v2[22:0]);
        if (v3 >= {1'b0, PWO_Q}) begin
            v3 = v3 - {1'b0, PWO_Q};
        end
        return v3[COEFF_W-1:0];
    endfunction

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            prod_d[i] = mod_mul(lane.a[i], lane.b[i]);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= lane.valid;
        end
    end

    // Forward c and address alongside the products
    always_ff @(posedge clk) begin
        prod_o    <= prod_d;
        c_o       <= lane.c;
        wr_addr_o <= lane.wr_addr;
    end

endmodule

`default_nettype wire

/* src/pwo_add_lanes.sv */
// Four modular adder/subtractor lanes
//   a + b or a - b mod q with a single correction step
//   same one-cycle latency as the multiplier lanes

`timescale 1ns/10ps
`default_nettype none

module pwo_add_lanes (
    input  logic               clk,
    input  logic               reset_n,
    pwo_lane_if.add_dst        lane,
    input  pwo_pkg::pwo_mode_e mode_i,
    output pwo_pkg::lanes_t    sum_o
);
    import pwo_pkg::*;

    lanes_t sum_d;

    // Borrow out of the 24-bit difference means add q back
    function automatic coeff_t mod_sub(coeff_t x, coeff_t y);
        logic [COEFF_W:0] d;
        d = {1'b0, x} - {1'b0, y};
        if (d[COEFF_W]) begin
            d = d + {1'b0, PWO_Q};
        end
        return d[COEFF_W-1:0];
    endfunction

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            if (mode_i == PWO_SUB) begin
                sum_d[i] = mod_sub(lane.a[i], lane.b[i]);
            end else begin
                sum_d[i] = mod_add(lane.a[i], lane.b[i]);
            end
        end
    end

    // Result only moves when a word is presented
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum_o <= '0;
        end else if (lane.valid) begin
            sum_o <= sum_d;
        end
    end

endmodule

`default_nettype wire

/* src/pwo_combine.sv */
// Result select and write stage for memory c
//   multiply result plus old c, or the adder result
//   slot packing and registered write port
//   word count that flags the last write of a run

`timescale 1ns/10ps
`default_nettype none

module pwo_combine (
    input  logic                        clk,
    input  logic                        reset_n,
    input  pwo_pkg::pwo_mode_e          mode_i,
    input  logic                        valid_i,
    input  pwo_pkg::lanes_t             prod_i,
    input  pwo_pkg::lanes_t             sum_i,
    input  pwo_pkg::lanes_t             c_i,
    input  pwo_pkg::addr_t              wr_addr_i,
    output logic                        c_wr_en_o,
    output pwo_pkg::addr_t              c_wr_addr_o,
    output logic [pwo_pkg::WORD_W-1:0]  c_wr_data_o,
    output logic                        wr_done_o
);
    import pwo_pkg::*;

    lanes_t            res;
    logic [WORD_W-1:0] word_d;
    logic [IDX_W-1:0]  cnt_q;
    logic              last;

    // ====================
    // Lane select
    // ====================
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            if (mode_i == PWO_MUL) begin
                // c is zero here when not accumulating
                res[i] = mod_add(prod_i[i], c_i[i]);
            end else begin
                res[i] = sum_i[i];
            end
        end
    end

    // Top bit of every slot written as zero
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            word_d[i*SLOT_W +: SLOT_W] = {1'b0, res[i]};
        end
    end

    assign last = valid_i && (cnt_q == IDX_W'(POLY_WORDS - 1));

    // ====================
    // Write stage
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            c_wr_en_o <= 1'b0;
            wr_done_o <= 1'b0;
            cnt_q     <= '0;
        end else begin
            c_wr_en_o <= valid_i;
            wr_done_o <= last;
            // Wraps to zero after the last word of a run
            if (valid_i) begin
                cnt_q <= cnt_q + IDX_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        c_wr_addr_o <= wr_addr_i;
        c_wr_data_o <= word_d;
    end

endmodule

`default_nettype wire

/* src/pwo_top.sv */
// Pointwise multiply / add / subtract unit, top level
//   plain memory ports for operands a, b and destination c
//   sequencer, multiplier and adder lanes, write stage

`timescale 1ns/10ps
`default_nettype none

module pwo_top (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        start_i,
    input  pwo_pkg::pwo_mode_e          mode_i,
    input  logic                        accumulate_i,
    input  pwo_pkg::addr_t              a_base_i,
    input  pwo_pkg::addr_t              b_base_i,
    input  pwo_pkg::addr_t              c_base_i,
    output logic                        rd_en_o,
    output pwo_pkg::addr_t              a_rd_addr_o,
    output pwo_pkg::addr_t              b_rd_addr_o,
    input  logic [pwo_pkg::WORD_W-1:0]  a_rd_data_i,
    input  logic [pwo_pkg::WORD_W-1:0]  b_rd_data_i,
    output logic                        c_rd_en_o,
    output pwo_pkg::addr_t              c_rd_addr_o,
    input  logic [pwo_pkg::WORD_W-1:0]  c_rd_data_i,
    output logic                        c_wr_en_o,
    output pwo_pkg::addr_t              c_wr_addr_o,
    output logic [pwo_pkg::WORD_W-1:0]  c_wr_data_o,
    output logic                        busy_o,
    output logic                        done_o
);
    import pwo_pkg::*;

    pwo_mode_e mode;
    logic      wr_done;
    // Multiplier side carries valid, c and address for both lane types
    logic      mul_valid;
    lanes_t    mul_prod;
    lanes_t    mul_c;
    addr_t     mul_wr_addr;
    lanes_t    add_sum;

    pwo_lane_if lane_if ();

    pwo_seq pwo_seq_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .a_base_i     (a_base_i),
        .b_base_i     (b_base_i),
        .c_base_i     (c_base_i),
        .rd_en_o      (rd_en_o),
        .a_rd_addr_o  (a_rd_addr_o),
        .b_rd_addr_o  (b_rd_addr_o),
        .c_rd_en_o    (c_rd_en_o),
        .c_rd_addr_o  (c_rd_addr_o),
        .a_rd_data_i  (a_rd_data_i),
        .b_rd_data_i  (b_rd_data_i),
        .c_rd_data_i  (c_rd_data_i),
        .wr_done_i    (wr_done),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .mode_o       (mode),
        .lane         (lane_if.src)
    );

    pwo_mul_lanes pwo_mul_lanes_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .lane      (lane_if.mul_dst),
        .valid_o   (mul_valid),
        .prod_o    (mul_prod),
        .c_o       (mul_c),
        .wr_addr_o (mul_wr_addr)
    );

    pwo_add_lanes pwo_add_lanes_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .lane    (lane_if.add_dst),
        .mode_i  (mode),
        .sum_o   (add_sum)
    );

    pwo_combine pwo_combine_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .mode_i      (mode),
        .valid_i     (mul_valid),
        .prod_i      (mul_prod),
        .sum_i       (add_sum),
        .c_i         (mul_c),
        .wr_addr_i   (mul_wr_addr),
        .c_wr_en_o   (c_wr_en_o),
        .c_wr_addr_o (c_wr_addr_o),
        .c_wr_data_o (c_wr_data_o),
        .wr_done_o   (wr_done)
    );

endmodule

`default_nettype wire

/* testbench/pwo_sva.sv */
// Protocol checks for the pointwise unit, bound to its top level
//   write count and address order per run
//   read to write latency, done and busy timing

`timescale 1ns/10ps
`default_nettype none

module pwo_sva (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           start_i,
    input  logic           busy_i,
    input  logic           done_i,
    input  logic           rd_en_i,
    input  logic           c_wr_en_i,
    input  pwo_pkg::addr_t c_wr_addr_i,
    input  pwo_pkg::addr_t c_base_i
);
    import pwo_pkg::*;

    // Writes seen since the last accepted start
    logic [IDX_W:0] wr_cnt;
    int unsigned    fail_cnt = 0;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_cnt <= '0;
        end else if (start_i && !busy_i) begin
            wr_cnt <= '0;
        end else if (c_wr_en_i) begin
            wr_cnt <= wr_cnt + (IDX_W+1)'(1);
        end
    end

    // Write k lands at c_base + k, one polynomial at most
    addr_order: assert property (@(posedge clk) disable iff (!reset_n)
        c_wr_en_i |-> (wr_cnt < (IDX_W+1)'(POLY_WORDS))
                      && (c_wr_addr_i == c_base_i + addr_t'(wr_cnt)))
        else begin
            fail_cnt++;
            $error("write address out of order or too many writes in a run");
        end

    write_count: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |-> (wr_cnt == (IDX_W+1)'(POLY_WORDS)))
        else begin
            fail_cnt++;
            $error("run ended without exactly one polynomial of writes");
        end

    // Read request to write is four cycles
    wr_latency: assert property (@(posedge clk) disable iff (!reset_n)
        c_wr_en_i == $past(rd_en_i, 4))
        else begin
            fail_cnt++;
            $error("write does not follow its read by four cycles");
        end

    done_timing: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |-> $past(c_wr_en_i) && !c_wr_en_i && !busy_i && $past(busy_i))
        else begin
            fail_cnt++;
            $error("done is not one cycle after the last write with busy falling");
        end

    done_single: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |=> !done_i)
        else begin
            fail_cnt++;
            $error("done held for more than one cycle");
        end

    busy_end: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(busy_i) |-> done_i)
        else begin
            fail_cnt++;
            $error("busy fell without done");
        end

endmodule

`default_nettype wire

/* testbench/tb_pwo_top.sv */
// Testbench for the pointwise polynomial unit
//   clock, reset and three behavioral word memories
//   LFSR operands, multiply, add and subtract runs
//   checking assertions and the result report

`timescale 1ns/10ps
`default_nettype none

module tb_pwo_top;
    import pwo_pkg::*;

    localparam int     CLK_NS      = 4;
    localparam int     RESET_CYC   = 16;
    localparam int     NUM_TESTS   = 6;
    localparam int     TEST_CYC    = 100;
    localparam int     WATCHDOG_NS = 2 * NUM_TESTS * TEST_CYC * CLK_NS + RESET_CYC * CLK_NS;
    localparam int     MEM_AW      = 8;
    localparam int     MEM_DEPTH   = 1 << MEM_AW;
    localparam longint Q           = longint'(PWO_Q);

    logic              clk = 1'b0;
    logic              reset_n;
    logic              start_i;
    pwo_mode_e         mode_i;
    logic              accumulate_i;
    addr_t             a_base_i;
    addr_t             b_base_i;
    addr_t             c_base_i;
    logic              rd_en_o;
    addr_t             a_rd_addr_o;
    addr_t             b_rd_addr_o;
    logic [WORD_W-1:0] a_rd_data_i = '0;
    logic [WORD_W-1:0] b_rd_data_i = '0;
    logic              c_rd_en_o;
    addr_t             c_rd_addr_o;
    logic [WORD_W-1:0] c_rd_data_i = '0;
    logic              c_wr_en_o;
    addr_t             c_wr_addr_o;
    logic [WORD_W-1:0] c_wr_data_o;
    logic              busy_o;
    logic              done_o;

    // Operand memories, destination memory and its image before a run
    logic [WORD_W-1:0] mem_a  [MEM_DEPTH];
    logic [WORD_W-1:0] mem_b  [MEM_DEPTH];
    logic [WORD_W-1:0] mem_c  [MEM_DEPTH];
    logic [WORD_W-1:0] c_init [MEM_DEPTH];
    logic              load_c;

    logic [15:0] lfsr_state;
    pwo_mode_e   exp_mode;
    logic        exp_acc;
    logic        started;
    int          assert_errs = 0;
    int          proc_errs;
    int          tests_run;

    pwo_top pwo_top_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .a_base_i     (a_base_i),
        .b_base_i     (b_base_i),
        .c_base_i     (c_base_i),
        .rd_en_o      (rd_en_o),
        .a_rd_addr_o  (a_rd_addr_o),
        .b_rd_addr_o  (b_rd_addr_o),
        .a_rd_data_i  (a_rd_data_i),
        .b_rd_data_i  (b_rd_data_i),
        .c_rd_en_o    (c_rd_en_o),
        .c_rd_addr_o  (c_rd_addr_o),
        .c_rd_data_i  (c_rd_data_i),
        .c_wr_en_o    (c_wr_en_o),
        .c_wr_addr_o  (c_wr_addr_o),
        .c_wr_data_o  (c_wr_data_o),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    bind pwo_top pwo_sva pwo_sva_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_i     (start_i),
        .busy_i      (busy_o),
        .done_i      (done_o),
        .rd_en_i     (rd_en_o),
        .c_wr_en_i   (c_wr_en_o),
        .c_wr_addr_i (c_wr_addr_o),
        .c_base_i    (c_base_i)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // ====================
    // Memory models
    // ====================
    // One cycle read latency, write port for c, bulk load of c before a run
    always @(posedge clk) begin
        if (rd_en_o) begin
            a_rd_data_i <= mem_a[MEM_AW'(a_rd_addr_o)];
            b_rd_data_i <= mem_b[MEM_AW'(b_rd_addr_o)];
        end
        if (c_rd_en_o) begin
            c_rd_data_i <= mem_c[MEM_AW'(c_rd_addr_o)];
        end
        if (c_wr_en_o) begin
            mem_c[MEM_AW'(c_wr_addr_o)] <= c_wr_data_o;
        end
        if (load_c) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem_c[i] <= c_init[i];
            end
        end
    end

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [WORD_W-1:0] rand_word();
        logic [WORD_W-1:0] w;
        w = '0;
        for (int i = 0; i < LANES; i++) begin
            w[i*SLOT_W +: COEFF_W] = COEFF_W'(take_bits(COEFF_W) % 32'(PWO_Q));
        end
        return w;
    endfunction

    // Reference result for one destination word, plain integer arithmetic
    function automatic logic [WORD_W-1:0] exp_word(addr_t wa);
        addr_t             k;
        logic [WORD_W-1:0] aw;
        logic [WORD_W-1:0] bw;
        logic [WORD_W-1:0] cw;
        logic [WORD_W-1:0] r;
        longint            x;
        longint            y;
        longint            z;
        longint            v;
        k  = wa - c_base_i;
        aw = mem_a[MEM_AW'(a_base_i + k)];
        bw = mem_b[MEM_AW'(b_base_i + k)];
        cw = c_init[MEM_AW'(wa)];
        r  = '0;
        for (int i = 0; i < LANES; i++) begin
            x = longint'(aw[i*SLOT_W +: COEFF_W]);
            y = longint'(bw[i*SLOT_W +: COEFF_W]);
            z = longint'(cw[i*SLOT_W +: COEFF_W]);
            case (exp_mode)
                PWO_ADD: v = (x + y) % Q;
                PWO_SUB: v = (x - y + Q) % Q;
                default: begin
                    v = (x * y) % Q;
                    if (exp_acc) begin
                        v = (v + z) % Q;
                    end
                end
            endcase
            r[i*SLOT_W +: SLOT_W] = SLOT_W'(v);
        end
        return r;
    endfunction

    function automatic int total_errors();
        return assert_errs + proc_errs + int'(pwo_top_inst.pwo_sva_inst.fail_cnt);
    endfunction

    // ====================
    // Checks
    // ====================
    idle_check: assert property (@(posedge clk) disable iff (!reset_n)
        !started |-> !(rd_en_o || c_rd_en_o || c_wr_en_o || busy_o || done_o))
        else begin
            $display("control outputs active after reset before any start");
            assert_errs++;
        end

    data_check: assert property (@(posedge clk) disable iff (!reset_n)
        c_wr_en_o |-> (c_wr_data_o == exp_word(c_wr_addr_o)))
        else begin
            $display("FAIL c_wr_data_o at %h: got %h, expected %h",
                     $sampled(c_wr_addr_o), $sampled(c_wr_data_o),
                     exp_word($sampled(c_wr_addr_o)));
            assert_errs++;
        end

    // Old c is only fetched for multiply with accumulate
    c_read_check: assert property (@(posedge clk) disable iff (!reset_n)
        c_rd_en_o |-> (rd_en_o && exp_mode == PWO_MUL && exp_acc))
        else begin
            $display("c_rd_en_o high outside a multiply with accumulate");
            assert_errs++;
        end

    restart_check: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(rd_en_o) |-> $past(start_i && !busy_o))
        else begin
            $display("rd_en_o rose without an accepted start");
            assert_errs++;
        end

    // ====================
    // Stimulus
    // ====================
    task automatic fill_memories();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem_a[i]  = rand_word();
            mem_b[i]  = rand_word();
            c_init[i] = rand_word();
        end
        @(posedge clk);
        load_c <= 1'b1;
        @(posedge clk);
        load_c <= 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        int errs;
        errs = total_errors() - errs_before;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    task automatic run_op(
        input string     name,
        input pwo_mode_e mode,
        input logic      acc,
        input addr_t     a_base,
        input addr_t     b_base,
        input addr_t     c_base,
        input logic      poke_busy
    );
        int errs_before;
        int wait_cyc;
        errs_before = total_errors();
        fill_memories();
        @(posedge clk);
        exp_mode     = mode;
        exp_acc      = acc;
        started      <= 1'b1;
        start_i      <= 1'b1;
        mode_i       <= mode;
        accumulate_i <= acc;
        a_base_i     <= a_base;
        b_base_i     <= b_base;
        c_base_i     <= c_base;
        @(posedge clk);
        start_i <= 1'b0;
        wait_cyc = 0;
        if (poke_busy) begin
            // Once during the reads, once after them while still busy
            repeat (10) @(posedge clk);
            start_i <= 1'b1;
            mode_i  <= PWO_ADD;
            @(posedge clk);
            start_i <= 1'b0;
            @(negedge clk);
            while (rd_en_o && wait_cyc < TEST_CYC) begin
                @(negedge clk);
                wait_cyc++;
            end
            @(posedge clk);
            start_i <= 1'b1;
            @(posedge clk);
            start_i <= 1'b0;
        end
        wait_cyc = 0;
        @(negedge clk);
        while (!done_o && wait_cyc < TEST_CYC) begin
            @(negedge clk);
            wait_cyc++;
        end
        if (!done_o) begin
            $display("test %s: done_o did not rise within %0d cycles", name, TEST_CYC);
            proc_errs++;
        end
        repeat (8) @(posedge clk);
        report_test(name, errs_before);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    initial begin
        reset_n      = 1'b0;
        start_i      = 1'b0;
        mode_i       = PWO_MUL;
        accumulate_i = 1'b0;
        a_base_i     = '0;
        b_base_i     = '0;
        c_base_i     = '0;
        load_c       = 1'b0;
        started      = 1'b0;
        exp_mode     = PWO_MUL;
        exp_acc      = 1'b0;
        lfsr_state   = 16'd17485;
        proc_errs    = 0;
        tests_run    = 0;
        repeat (RESET_CYC) @(posedge clk);
        reset_n <= 1'b1;
        // Outputs are watched for a while before the first start
        repeat (10) @(posedge clk);
        report_test("idle_after_reset", 0);
        run_op("mul_acc", PWO_MUL, 1'b1, 15'h040, 15'h000, 15'h0c0, 1'b0);
        // Stale old c on the read port must not leak into a plain multiply
        run_op("mul", PWO_MUL, 1'b0, 15'h000, 15'h040, 15'h080, 1'b0);
        run_op("add", PWO_ADD, 1'b1, 15'h080, 15'h0c0, 15'h000, 1'b0);
        run_op("sub", PWO_SUB, 1'b1, 15'h0c0, 15'h080, 15'h040, 1'b0);
        run_op("start_while_busy", PWO_MUL, 1'b1, 15'h010, 15'h020, 15'h030, 1'b1);
        $display("tests %0d, errors %0d", tests_run, total_errors());
        if (total_errors() == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
src/pwo_pkg.sv
src/pwo_lane_if.sv
src/pwo_seq.sv
src/pwo_mul_lanes.sv
src/pwo_add_lanes.sv
src/pwo_combine.sv
src/pwo_top.sv
testbench/pwo_sva.sv
testbench/tb_pwo_top.sv

/* run.sh */
#!/bin/sh
# Build and run the pointwise unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f files.f --top-module tb_pwo_top -o sim_pwo
out=$(./obj_dir/sim_pwo +verilator+error+limit+100 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1
